//--- src/llc_pkg.sv
`default_nettype none

package llc_pkg;

    // ====================
    // geometry
    // ====================
    localparam int SET_W = 4;
    localparam int SETS = 16;
    localparam int WAYS = 4;
    localparam int WAY_W = 2;
    localparam int TAG_W = 6;
    localparam int LINE_ADDR_W = SET_W + TAG_W;
    localparam int LINE_W = 32;

    typedef logic [SET_W-1:0] set_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [LINE_W-1:0] line_t;

    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } llc_state_e;

    typedef enum logic [2:0] {
        SWEEP,
        DECODE,
        READ_SET,
        LOOKUP,
        PROCESS,
        UPDATE
    } llc_phase_e;

    // ====================
    // addresses and lines
    // ====================
    typedef struct packed {
        tag_t tag;
        set_t set;
    } line_fields_t;

    // same line address, seen flat by memory or split by the cache.
    typedef union packed {
        logic [LINE_ADDR_W-1:0] flat;
        line_fields_t           fields;
    } line_addr_u;

    typedef struct packed {
        llc_state_e state;
        logic       dirty;
        tag_t       tag;
    } way_meta_t;

    typedef way_meta_t [WAYS-1:0] set_meta_t;
    typedef line_t [WAYS-1:0] set_lines_t;

    // ====================
    // channels
    // ====================
    typedef struct packed {
        logic       write;
        line_addr_u addr;
        line_t      line;
    } llc_req_t;

    typedef struct packed {
        line_addr_u addr;
        line_t      line;
    } llc_rsp_t;

    typedef struct packed {
        logic       write;
        line_addr_u addr;
        line_t      line;
    } mem_req_t;

    typedef struct packed {
        logic       hit;
        way_t       way;
        logic       victim_dirty;
        line_addr_u victim_addr;
    } lookup_t;

endpackage

`default_nettype wire

//--- src/llc_set_counter.sv
`timescale 1ns/1ps
`default_nettype none

module llc_set_counter (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     sweep_en_i,
    output llc_pkg::set_t set_o,
    output logic          sweep_last_o
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            set_o <= '0;
        end else if (sweep_en_i) begin
            set_o <= set_o + 1'b1; // wraps back to set 0 after the last one.
        end
    end

    assign sweep_last_o = sweep_en_i && (set_o == llc_pkg::set_t'(llc_pkg::SETS - 1));

endmodule

`default_nettype wire

//--- src/llc_localmem.sv
`timescale 1ns/1ps
`default_nettype none

module llc_localmem (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                sweep_en_i,
    input  wire llc_pkg::set_t       sweep_set_i,
    input  wire logic                rd_en_i,
    input  wire llc_pkg::set_t       rd_set_i,
    input  wire logic                wr_en_i,
    input  wire llc_pkg::set_t       wr_set_i,
    input  wire llc_pkg::set_meta_t  wr_meta_i,
    input  wire llc_pkg::set_lines_t wr_lines_i,
    input  wire llc_pkg::way_t       wr_evict_way_i,
    output llc_pkg::set_meta_t       rd_meta_o,
    output llc_pkg::set_lines_t      rd_lines_o,
    output llc_pkg::way_t            rd_evict_way_o
);

    llc_pkg::set_meta_t meta_mem [llc_pkg::SETS];
    llc_pkg::set_lines_t line_mem [llc_pkg::SETS];
    llc_pkg::way_t evict_mem [llc_pkg::SETS];

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk) begin
        if (sweep_en_i) begin
            meta_mem[sweep_set_i] <= '0; // all ways INVALID and clean.
            evict_mem[sweep_set_i] <= '0;
        end else if (wr_en_i) begin
            meta_mem[wr_set_i] <= wr_meta_i;
            line_mem[wr_set_i] <= wr_lines_i;
            evict_mem[wr_set_i] <= wr_evict_way_i;
        end
    end

    // ====================
    // read port
    // ====================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_meta_o <= '0;
            rd_evict_way_o <= '0;
        end else if (rd_en_i) begin
            rd_meta_o <= meta_mem[rd_set_i];
            rd_evict_way_o <= evict_mem[rd_set_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_lines_o <= line_mem[rd_set_i];
        end
    end

endmodule

`default_nettype wire

//--- src/llc_set_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module llc_set_buffer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire llc_pkg::llc_req_t   req_i,
    input  wire logic                req_fire_i,
    input  wire logic                lookup_en_i,
    input  wire logic                update_en_i,
    input  wire llc_pkg::set_meta_t  rd_meta_i,
    input  wire llc_pkg::set_lines_t rd_lines_i,
    input  wire llc_pkg::way_t       rd_evict_way_i,
    input  wire llc_pkg::lookup_t    lookup_i,
    input  wire logic                fill_i,
    input  wire llc_pkg::line_t      fill_line_i,
    output llc_pkg::llc_req_t        req_o,
    output llc_pkg::set_meta_t       meta_o,
    output llc_pkg::set_lines_t      lines_o,
    output llc_pkg::way_t            evict_way_o
);

    llc_pkg::set_meta_t meta_q;
    llc_pkg::set_lines_t lines_q;
    llc_pkg::way_t evict_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            meta_q <= '0;
            evict_q <= '0;
        end else if (lookup_en_i) begin
            meta_q <= rd_meta_i;
            evict_q <= rd_evict_way_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire_i) begin
            req_o <= req_i;
        end
        if (lookup_en_i) begin
            lines_q <= rd_lines_i;
        end else if (fill_i) begin
            lines_q[lookup_i.way] <= fill_line_i; // line fetched on a read miss.
        end
    end

    // during UPDATE the request is applied to the selected way.
    always_comb begin
        meta_o = meta_q;
        lines_o = lines_q;
        evict_way_o = evict_q;
        if (update_en_i) begin
            if (req_o.write) begin
                lines_o[lookup_i.way] = req_o.line;
                meta_o[lookup_i.way].dirty = 1'b1;
            end
            if (!lookup_i.hit) begin
                meta_o[lookup_i.way].state = llc_pkg::VALID;
                meta_o[lookup_i.way].tag = req_o.addr.fields.tag;
                meta_o[lookup_i.way].dirty = req_o.write;
                evict_way_o = evict_q + 1'b1; // round robin, wraps at WAYS.
            end
        end
    end

endmodule

`default_nettype wire

//--- src/llc_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module llc_lookup (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               lookup_en_i,
    input  wire llc_pkg::line_addr_u req_addr_i,
    input  wire llc_pkg::set_meta_t rd_meta_i,
    input  wire llc_pkg::way_t      rd_evict_way_i,
    output llc_pkg::lookup_t        lookup_o
);

    llc_pkg::lookup_t res;
    logic hit;
    llc_pkg::way_t hit_way, sel;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < llc_pkg::WAYS; w++) begin
            if (rd_meta_i[w].state == llc_pkg::VALID &&
                rd_meta_i[w].tag == req_addr_i.fields.tag) begin
                hit = 1'b1;
                hit_way = llc_pkg::way_t'(w);
            end
        end
        sel = hit ? hit_way : rd_evict_way_i;
        res.hit = hit;
        res.way = sel;
        res.victim_dirty = !hit && rd_meta_i[sel].state == llc_pkg::VALID &&
                           rd_meta_i[sel].dirty;
        res.victim_addr.fields.tag = rd_meta_i[sel].tag; // victim lives in the same set.
        res.victim_addr.fields.set = req_addr_i.fields.set;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_o <= '0;
        end else if (lookup_en_i) begin
            lookup_o <= res;
        end
    end

endmodule

`default_nettype wire

//--- src/llc_process.sv
`timescale 1ns/1ps
`default_nettype none

module llc_process (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              process_en_i,
    input  wire llc_pkg::llc_req_t req_i,
    input  wire llc_pkg::lookup_t  lookup_i,
    input  wire llc_pkg::line_t    victim_line_i,
    input  wire logic              mem_req_ready_i,
    output logic                   mem_req_valid_o,
    output llc_pkg::mem_req_t      mem_req_o,
    input  wire logic              mem_rsp_valid_i,
    input  wire llc_pkg::line_t    mem_rsp_line_i,
    output logic                   mem_rsp_ready_o,
    output logic                   fill_o,
    output llc_pkg::line_t         fill_line_o,
    output logic                   process_done_o
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_WB,
        P_FETCH,
        P_FILL
    } step_e;

    step_e step_q, step_d;
    logic need_wb, need_fetch;

    assign need_wb = !lookup_i.hit && lookup_i.victim_dirty;
    assign need_fetch = !lookup_i.hit && !req_i.write; // full-line writes fetch nothing.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step_q <= P_IDLE;
        end else begin
            step_q <= step_d;
        end
    end

    // ====================
    // step sequencing
    // ====================
    always_comb begin
        step_d = step_q;
        process_done_o = 1'b0;
        case (step_q)
            P_IDLE: begin
                if (process_en_i) begin
                    if (need_wb) begin
                        step_d = P_WB;
                    end else if (need_fetch) begin
                        step_d = P_FETCH;
                    end else begin
                        process_done_o = 1'b1; // hit or clean write miss.
                    end
                end
            end
            P_WB: begin
                if (mem_req_ready_i) begin
                    if (need_fetch) begin
                        step_d = P_FETCH;
                    end else begin
                        step_d = P_IDLE;
                        process_done_o = 1'b1;
                    end
                end
            end
            P_FETCH: begin
                if (mem_req_ready_i) begin
                    step_d = P_FILL;
                end
            end
            P_FILL: begin
                if (mem_rsp_valid_i) begin
                    step_d = P_IDLE;
                    process_done_o = 1'b1;
                end
            end
            default: step_d = P_IDLE;
        endcase
    end

    assign mem_req_valid_o = (step_q == P_WB) || (step_q == P_FETCH);

    always_comb begin
        if (step_q == P_WB) begin
            mem_req_o = '{write: 1'b1, addr: lookup_i.victim_addr, line: victim_line_i};
        end else begin
            mem_req_o = '{write: 1'b0, addr: req_i.addr, line: '0};
        end
    end

    assign mem_rsp_ready_o = (step_q == P_FILL);
    assign fill_o = mem_rsp_ready_o && mem_rsp_valid_i;
    assign fill_line_o = mem_rsp_line_i;

endmodule

`default_nettype wire

//--- src/llc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module llc_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic req_valid_i,
    input  wire logic sweep_last_i,
    input  wire logic process_done_i,
    input  wire logic rsp_ready_i,
    output logic      sweep_en_o,
    output logic      decode_en_o,
    output logic      rd_set_en_o,
    output logic      lookup_en_o,
    output logic      process_en_o,
    output logic      update_en_o,
    output logic      req_ready_o,
    output logic      rsp_valid_o
);

    llc_pkg::llc_phase_e phase_q, phase_d;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase_q <= llc_pkg::SWEEP; // every set is invalidated first.
        end else begin
            phase_q <= phase_d;
        end
    end

    // ====================
    // next phase
    // ====================
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            llc_pkg::SWEEP: begin
                if (sweep_last_i) begin
                    phase_d = llc_pkg::DECODE;
                end
            end
            llc_pkg::DECODE: begin
                if (req_valid_i) begin
                    phase_d = llc_pkg::READ_SET;
                end
            end
            llc_pkg::READ_SET: phase_d = llc_pkg::LOOKUP;
            llc_pkg::LOOKUP:   phase_d = llc_pkg::PROCESS;
            llc_pkg::PROCESS: begin
                if (process_done_i) begin
                    phase_d = llc_pkg::UPDATE;
                end
            end
            llc_pkg::UPDATE: begin
                if (rsp_ready_i) begin
                    phase_d = llc_pkg::DECODE; // response taken.
                end
            end
            default: phase_d = llc_pkg::SWEEP;
        endcase
    end

    assign sweep_en_o = (phase_q == llc_pkg::SWEEP);
    assign decode_en_o = (phase_q == llc_pkg::DECODE);
    assign rd_set_en_o = (phase_q == llc_pkg::READ_SET);
    assign lookup_en_o = (phase_q == llc_pkg::LOOKUP);
    assign process_en_o = (phase_q == llc_pkg::PROCESS);
    assign update_en_o = (phase_q == llc_pkg::UPDATE);

    assign req_ready_o = decode_en_o;
    assign rsp_valid_o = update_en_o; // held for the whole UPDATE phase.

endmodule

`default_nettype wire

//--- src/llc_top.sv
`timescale 1ns/1ps
`default_nettype none

module llc_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid_i,
    input  wire llc_pkg::llc_req_t req_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output llc_pkg::llc_rsp_t      rsp_o,
    input  wire logic              rsp_ready_i,
    output logic                   mem_req_valid_o,
    output llc_pkg::mem_req_t      mem_req_o,
    input  wire logic              mem_req_ready_i,
    input  wire logic              mem_rsp_valid_i,
    input  wire llc_pkg::line_t    mem_rsp_line_i,
    output logic                   mem_rsp_ready_o
);

    logic sweep_en, decode_en, rd_set_en, lookup_en, process_en, update_en;
    logic sweep_last, process_done, req_fire, fill;
    llc_pkg::set_t sweep_set;
    llc_pkg::llc_req_t held_req;
    llc_pkg::set_meta_t rd_meta, buf_meta;
    llc_pkg::set_lines_t rd_lines, buf_lines;
    llc_pkg::way_t rd_evict_way, buf_evict_way;
    llc_pkg::lookup_t lkp;
    llc_pkg::line_t fill_line, victim_line;

    assign req_fire = req_valid_i & decode_en; // same level as req_ready_o.
    assign victim_line = buf_lines[lkp.way];
    assign rsp_o = '{addr: held_req.addr, line: buf_lines[lkp.way]};

    llc_ctrl ctrl0 (
        .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .sweep_last_i(sweep_last),
        .process_done_i(process_done), .rsp_ready_i(rsp_ready_i),
        .sweep_en_o(sweep_en), .decode_en_o(decode_en), .rd_set_en_o(rd_set_en),
        .lookup_en_o(lookup_en), .process_en_o(process_en), .update_en_o(update_en),
        .req_ready_o(req_ready_o), .rsp_valid_o(rsp_valid_o)
    );

    llc_set_counter counter0 (
        .clk(clk), .rst(rst), .sweep_en_i(sweep_en),
        .set_o(sweep_set), .sweep_last_o(sweep_last)
    );

    llc_localmem mem0 (
        .clk(clk), .rst(rst), .sweep_en_i(sweep_en), .sweep_set_i(sweep_set),
        .rd_en_i(rd_set_en), .rd_set_i(held_req.addr.fields.set),
        .wr_en_i(update_en), .wr_set_i(held_req.addr.fields.set),
        .wr_meta_i(buf_meta), .wr_lines_i(buf_lines), .wr_evict_way_i(buf_evict_way),
        .rd_meta_o(rd_meta), .rd_lines_o(rd_lines), .rd_evict_way_o(rd_evict_way)
    );

    llc_set_buffer buf0 (
        .clk(clk), .rst(rst), .req_i(req_i), .req_fire_i(req_fire),
        .lookup_en_i(lookup_en), .update_en_i(update_en),
        .rd_meta_i(rd_meta), .rd_lines_i(rd_lines), .rd_evict_way_i(rd_evict_way),
        .lookup_i(lkp), .fill_i(fill), .fill_line_i(fill_line),
        .req_o(held_req), .meta_o(buf_meta), .lines_o(buf_lines), .evict_way_o(buf_evict_way)
    );

    llc_lookup lookup0 (
        .clk(clk), .rst(rst), .lookup_en_i(lookup_en), .req_addr_i(held_req.addr),
        .rd_meta_i(rd_meta), .rd_evict_way_i(rd_evict_way), .lookup_o(lkp)
    );

    llc_process process0 (
        .clk(clk), .rst(rst), .process_en_i(process_en), .req_i(held_req),
        .lookup_i(lkp), .victim_line_i(victim_line),
        .mem_req_ready_i(mem_req_ready_i), .mem_req_valid_o(mem_req_valid_o),
        .mem_req_o(mem_req_o), .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_line_i(mem_rsp_line_i), .mem_rsp_ready_o(mem_rsp_ready_o),
        .fill_o(fill), .fill_line_o(fill_line), .process_done_o(process_done)
    );

endmodule

`default_nettype wire

//--- bench/llc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module llc_tb;

    localparam int MEM_WORDS = 1 << llc_pkg::LINE_ADDR_W;
    localparam int REQ_COUNT = 24;
    localparam int REQ_CYCLES = 80;
    localparam int CYCLE_LIMIT = 3 * (llc_pkg::SETS + 8) + REQ_COUNT * REQ_CYCLES;
    localparam int BP_OPS = 12;

    logic clk = 1'b0;
    logic rst;
    logic req_valid_i;
    llc_pkg::llc_req_t req_i;
    logic req_ready_o;
    logic rsp_valid_o;
    llc_pkg::llc_rsp_t rsp_o;
    logic rsp_ready_i;
    logic mem_req_valid_o;
    llc_pkg::mem_req_t mem_req_o;
    logic mem_req_ready_i;
    logic mem_rsp_valid_i;
    llc_pkg::line_t mem_rsp_line_i;
    logic mem_rsp_ready_o;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [15:0] lfsr_q = 16'd13;
    logic bp_en = 1'b0;

    llc_pkg::line_t mem_data [MEM_WORDS]; // memory seen by the DUT.
    llc_pkg::line_t ref_mem [MEM_WORDS];  // memory as the model expects it.
    logic m_valid [llc_pkg::SETS][llc_pkg::WAYS];
    logic m_dirty [llc_pkg::SETS][llc_pkg::WAYS];
    llc_pkg::tag_t m_tag [llc_pkg::SETS][llc_pkg::WAYS];
    llc_pkg::line_t m_line [llc_pkg::SETS][llc_pkg::WAYS];
    llc_pkg::way_t m_ptr [llc_pkg::SETS];

    llc_pkg::mem_req_t mem_log [$];
    llc_pkg::llc_rsp_t rsp_log [$];
    llc_pkg::mem_req_t exp_mem [$];

    logic mem_hold = 1'b0;
    logic rsp_hold = 1'b0;
    logic fetch_pending = 1'b0;
    llc_pkg::mem_req_t mem_held;
    llc_pkg::llc_rsp_t rsp_held;
    llc_pkg::line_t fetch_line;

    llc_top dut0 (
        .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .req_i(req_i),
        .req_ready_o(req_ready_o), .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
        .rsp_ready_i(rsp_ready_i), .mem_req_valid_o(mem_req_valid_o),
        .mem_req_o(mem_req_o), .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_line_i(mem_rsp_line_i),
        .mem_rsp_ready_o(mem_rsp_ready_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ====================
    // helpers and checks
    // ====================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11+1.
            lfsr_q = {lfsr_q[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic llc_pkg::line_addr_u make_addr(input llc_pkg::tag_t tag_v,
                                                      input llc_pkg::set_t set_v);
        llc_pkg::line_addr_u a;
        a.fields.tag = tag_v;
        a.fields.set = set_v;
        return a;
    endfunction

    task automatic check_rsp(input llc_pkg::llc_rsp_t got, input llc_pkg::llc_rsp_t exp,
                             input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_mem_req(input llc_pkg::mem_req_t got, input llc_pkg::mem_req_t exp,
                                 input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // ====================
    // memory and response side
    // ====================
    always begin
        @(negedge clk);
        if (!rst) begin
            mem_hold = 1'b0;
            rsp_hold = 1'b0;
            fetch_pending = 1'b0;
        end else begin
            if (mem_hold) begin
                check_flag(mem_req_valid_o, 1'b1, "memory request dropped before handshake");
                check_mem_req(mem_req_o, mem_held, "memory request changed while stalled");
            end
            if (rsp_hold) begin
                check_flag(rsp_valid_o, 1'b1, "response dropped before handshake");
                check_rsp(rsp_o, rsp_held, "response changed while stalled");
            end
            mem_hold = mem_req_valid_o && !mem_req_ready_i;
            mem_held = mem_req_o;
            rsp_hold = rsp_valid_o && !rsp_ready_i;
            rsp_held = rsp_o;
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                fetch_pending = 1'b0;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_log.push_back(mem_req_o);
                if (mem_req_o.write) begin
                    mem_data[mem_req_o.addr.flat] = mem_req_o.line; // write-back.
                end else begin
                    fetch_pending = 1'b1;
                    fetch_line = mem_data[mem_req_o.addr.flat];
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_log.push_back(rsp_o);
            end
        end
        @(posedge clk);
        #1;
        mem_rsp_valid_i = fetch_pending && rst;
        mem_rsp_line_i = fetch_pending ? fetch_line : '0;
        if (bp_en) begin
            mem_req_ready_i = rand_bits(1) != 0;
            rsp_ready_i = rand_bits(1) != 0;
        end else begin
            mem_req_ready_i = 1'b1;
            rsp_ready_i = 1'b1;
        end
    end

    // ====================
    // reference model
    // ====================
    task automatic model_reset();
        int s;
        int w;
        for (s = 0; s < llc_pkg::SETS; s++) begin
            m_ptr[s] = '0;
            for (w = 0; w < llc_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic model_apply(input logic write, input llc_pkg::line_addr_u addr,
                               input llc_pkg::line_t line, output llc_pkg::line_t rsp_line);
        llc_pkg::set_t s;
        llc_pkg::way_t w;
        logic hit;
        llc_pkg::mem_req_t mr;
        int i;
        s = addr.fields.set;
        w = m_ptr[s];
        hit = 1'b0;
        exp_mem.delete();
        for (i = 0; i < llc_pkg::WAYS; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == addr.fields.tag) begin
                hit = 1'b1;
                w = llc_pkg::way_t'(i);
            end
        end
        if (hit) begin
            if (write) begin
                m_line[s][w] = line;
                m_dirty[s][w] = 1'b1;
            end
        end else begin
            if (m_valid[s][w] && m_dirty[s][w]) begin
                mr.write = 1'b1;
                mr.addr = make_addr(m_tag[s][w], s);
                mr.line = m_line[s][w];
                exp_mem.push_back(mr);
                ref_mem[mr.addr.flat] = mr.line;
            end
            if (write) begin
                m_line[s][w] = line;
            end else begin
                mr.write = 1'b0;
                mr.addr = addr;
                mr.line = '0;
                exp_mem.push_back(mr);
                m_line[s][w] = ref_mem[addr.flat];
            end
            m_valid[s][w] = 1'b1;
            m_tag[s][w] = addr.fields.tag;
            m_dirty[s][w] = write;
            m_ptr[s] = llc_pkg::way_t'((int'(w) + 1) % llc_pkg::WAYS);
        end
        rsp_line = m_line[s][w];
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b0;
        req_valid_i = 1'b0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
    endtask

    task automatic do_request(input logic write, input llc_pkg::line_addr_u addr,
                              input llc_pkg::line_t line);
        llc_pkg::line_t exp_line;
        llc_pkg::llc_rsp_t exp_rsp;
        llc_pkg::llc_rsp_t got;
        int n_mem;
        int n_rsp;
        int i;
        n_mem = mem_log.size();
        n_rsp = rsp_log.size();
        model_apply(write, addr, line, exp_line);
        @(posedge clk);
        #1;
        req_i.write = write;
        req_i.addr = addr;
        req_i.line = line;
        req_valid_i = 1'b1;
        @(negedge clk);
        while (!req_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        while (rsp_log.size() == n_rsp) @(posedge clk);
        got = rsp_log[n_rsp];
        if (write) begin
            check_flag(got.addr.flat == addr.flat, 1'b1, "write response address");
        end else begin
            exp_rsp.addr = addr;
            exp_rsp.line = exp_line;
            check_rsp(got, exp_rsp, "read response");
        end
        check_flag(mem_log.size() - n_mem == exp_mem.size(), 1'b1,
                   $sformatf("memory request count for address %h", addr.flat));
        for (i = 0; i < exp_mem.size() && n_mem + i < mem_log.size(); i++) begin
            check_mem_req(mem_log[n_mem + i], exp_mem[i], $sformatf("memory request %0d", i));
        end
    endtask

    // ====================
    // tests
    // ====================
    task automatic test_reset_sweep();
        llc_pkg::line_addr_u a;
        int i;
        a = make_addr(6'h11, 4'd1);
        apply_reset();
        @(negedge clk);
        check_flag(rsp_valid_o, 1'b0, "response valid after reset");
        check_flag(mem_req_valid_o, 1'b0, "memory request valid after reset");
        check_flag(mem_rsp_ready_o, 1'b0, "memory response ready after reset");
        check_flag(req_ready_o, 1'b0, "request ready during sweep");
        for (i = 1; i < llc_pkg::SETS; i++) begin
            @(negedge clk);
            check_flag(req_ready_o, 1'b0, "request ready during sweep");
        end
        @(negedge clk);
        check_flag(req_ready_o, 1'b1, "request ready after sweep");
        do_request(1'b1, a, 32'hA5A5_0001);
        apply_reset();
        do_request(1'b0, a, '0); // the line was dropped, so this fetches.
    endtask

    task automatic test_read_miss();
        do_request(1'b0, make_addr(6'h2A, 4'd5), '0);
    endtask

    task automatic test_write_read_hit();
        llc_pkg::line_addr_u a;
        a = make_addr(6'h07, 4'd6);
        do_request(1'b1, a, 32'hC0DE_1234);
        do_request(1'b0, a, '0);
    endtask

    task automatic test_eviction();
        int i;
        for (i = 0; i <= llc_pkg::WAYS; i++) begin
            do_request(1'b1, make_addr(llc_pkg::tag_t'(i + 8), 4'd9), 32'hE000_0000 + i);
        end
        do_request(1'b0, make_addr(6'd8, 4'd9), '0); // must come back from memory.
    endtask

    task automatic test_back_pressure();
        logic op_write [BP_OPS];
        llc_pkg::line_addr_u op_addr [BP_OPS];
        llc_pkg::line_t op_line [BP_OPS];
        logic [31:0] r;
        logic [31:0] s;
        int i;
        for (i = 0; i < BP_OPS; i++) begin
            r = rand_bits(1);
            op_write[i] = r[0];
            r = rand_bits(3);
            s = rand_bits(1);
            op_addr[i] = make_addr({3'b101, r[2:0]}, s[0] ? 4'd13 : 4'd12);
            op_line[i] = rand_bits(32);
        end
        bp_en = 1'b1;
        for (i = 0; i < BP_OPS; i++) begin
            do_request(op_write[i], op_addr[i], op_line[i]);
        end
        bp_en = 1'b0;
    endtask

    initial begin
        int a;
        rst = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        rsp_ready_i = 1'b1;
        mem_req_ready_i = 1'b1;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i = '0;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem_data[a] = rand_bits(32);
            ref_mem[a] = mem_data[a];
        end
        test_reset_sweep();
        test_read_miss();
        test_write_read_hit();
        test_eviction();
        test_back_pressure();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/llc_pkg.sv
src/llc_set_counter.sv
src/llc_localmem.sv
src/llc_set_buffer.sv
src/llc_lookup.sv
src/llc_process.sv
src/llc_ctrl.sv
src/llc_top.sv
bench/llc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module llc_tb -f sources.f -o llc_sim
./obj_dir/llc_sim > sim.log
cat sim.log
if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
